//--- cpu_frontend_params.svh
// Width definitions shared by the CPU front end blocks
`ifndef CPU_FRONTEND_PARAMS_SVH
`define CPU_FRONTEND_PARAMS_SVH

// Instruction and data word width
`define WORD_BITS 16

// Instruction address width
// Cache request address is one word granular
`define PC_BITS 15

// Register index width
// Sixteen general registers
`define REG_BITS 4

`endif

//--- cpu_frontend_pkg.sv
// Shared types for the CPU front end, fetch FSM states and instruction opcodes
`default_nettype none

package cpu_frontend_pkg;

	// Fetch controller states
	typedef enum logic [3:0] {
		st_execute          = 4'd0,
		// Cache miss rewind, then wait for the line
		st_wait_cache1      = 4'd1,
		st_wait_cache2      = 4'd2,
		// Hazard countdown
		st_stall_2          = 4'd3,
		st_stall_3          = 4'd4,
		st_stall_4          = 4'd5,
		// Data memory not ready
		st_mem_stall1       = 4'd6,
		st_mem_stall2       = 4'd7,
		// Cache flush request and wait
		st_invalidate_cache = 4'd8,
		st_wait_invalidate  = 4'd9
	} fetch_state_t;

	// Top nibble of an instruction word
	typedef enum logic [3:0] {
		op_nop = 4'h0,
		op_add = 4'h1,
		op_sub = 4'h2,
		op_and = 4'h3,
		op_or  = 4'h4,
		op_cmp = 4'h5,
		op_ld  = 4'h6,
		op_st  = 4'h7,
		// 12-bit payload for the immediate register
		op_imm = 4'h8,
		op_br  = 4'h9
	} opcode_t;

endpackage

`default_nettype wire

//--- pipe_view_if.sv
// Read-only view of pipeline slots 0 to 3 for hazard detection
`timescale 1ns/1ns
`default_nettype none

`include "cpu_frontend_params.svh"

interface pipe_view_if;

	// Slot instruction words
	logic [`WORD_BITS-1:0] s0_word;
	logic [`WORD_BITS-1:0] s1_word;
	logic [`WORD_BITS-1:0] s2_word;
	logic [`WORD_BITS-1:0] s3_word;

	// Slot valid bits, low for bubbles
	logic s0_valid;
	logic s1_valid;
	logic s2_valid;
	logic s3_valid;

	// Driven by the pipeline slots
	modport source (
		output s0_word, s1_word, s2_word, s3_word,
		output s0_valid, s1_valid, s2_valid, s3_valid
	);

	// Read by the hazard check
	modport sink (
		input s0_word, s1_word, s2_word, s3_word,
		input s0_valid, s1_valid, s2_valid, s3_valid
	);

endinterface

`default_nettype wire

//--- cpu_fetch_control.sv
// Fetch controller with PC tracking, run/stall FSM and pipeline strobes
`timescale 1ns/1ns
`default_nettype none

`include "cpu_frontend_params.svh"

module cpu_fetch_control (
	input  wire                 CLK,
	input  wire                 RSTb,
	input  wire                 hazard_1,
	input  wire                 hazard_2,
	input  wire                 hazard_3,
	input  wire                 cache_miss,
	input  wire                 invalidate_cache,
	input  wire                 invalidation_done,
	input  wire                 data_memory_was_requested,
	input  wire                 data_memory_success,
	input  wire                 bank_switch,
	input  wire                 load_pc,
	input  wire [`PC_BITS-1:0]  new_pc,
	output logic [`PC_BITS-1:0] cache_request_address,
	output logic                take_fetch,
	output logic                freeze,
	output logic                flush
);
	import cpu_frontend_pkg::*;

	fetch_state_t        state;
	fetch_state_t        next_state;
	logic [`PC_BITS-1:0] pc;
	logic [`PC_BITS-1:0] pc_next;
	logic [`PC_BITS-1:0] pc_prev;
	logic [`PC_BITS-1:0] pc_prev_next;
	logic                mem_stall;
	logic                stall_any;

	// Memory stall trumps every other condition
	assign mem_stall = data_memory_was_requested && !data_memory_success;

	// Anything that rewinds the PC while executing
	assign stall_any = mem_stall || hazard_1 || hazard_2 || hazard_3 ||
		invalidate_cache || cache_miss;

	// Cache is addressed straight from the PC
	assign cache_request_address = pc;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			// Cache must be invalidated before the first fetch
			state   <= st_wait_invalidate;
			pc      <= '0;
			pc_prev <= '0;
		end else begin
			state   <= next_state;
			pc      <= pc_next;
			pc_prev <= pc_prev_next;
		end
	end

	// Next state
	always_comb begin
		next_state = state;
		case (state)
			st_execute: begin
				// Branch keeps running, flush handles the young slots
				if (load_pc)
					next_state = st_execute;
				else if (hazard_1)
					next_state = st_stall_2;
				else if (hazard_2)
					next_state = st_stall_3;
				else if (hazard_3)
					next_state = st_stall_4;
				else if (invalidate_cache)
					next_state = st_invalidate_cache;
				else if (cache_miss)
					next_state = st_wait_cache1;
			end
			// PC settles back on pc_prev here
			st_wait_cache1:      next_state = st_wait_cache2;
			st_wait_cache2:      if (!cache_miss) next_state = st_execute;
			st_stall_2:          next_state = st_stall_3;
			st_stall_3:          next_state = st_stall_4;
			st_stall_4:          next_state = st_execute;
			st_mem_stall1:       next_state = st_mem_stall2;
			st_mem_stall2:       if (!bank_switch) next_state = st_execute;
			st_invalidate_cache: next_state = st_wait_invalidate;
			st_wait_invalidate:  if (invalidation_done) next_state = st_execute;
			default:             next_state = st_wait_invalidate;
		endcase

		// Memory stall overrides, except while already draining the bank
		if (mem_stall && state != st_mem_stall2)
			next_state = st_mem_stall1;
	end

	// PC and previous PC
	always_comb begin
		pc_next      = pc;
		pc_prev_next = pc_prev;
		if (state == st_execute) begin
			if (mem_stall) begin
				pc_next = pc_prev;
			end else if (load_pc) begin
				// Branch target becomes the rewind point too
				pc_next      = new_pc;
				pc_prev_next = new_pc;
			end else if (stall_any) begin
				// Refetch the instruction sitting in stage0
				pc_next = pc_prev;
			end else begin
				pc_next      = pc + 1'b1;
				pc_prev_next = pc;
			end
		end
	end

	// Fetch only on a clean execute cycle
	assign take_fetch = (state == st_execute) && !load_pc && !stall_any;

	// Branch kills the younger slots
	assign flush = (state == st_execute) && load_pc && !mem_stall;

	// Later stages hold for the whole memory stall
	assign freeze = mem_stall || (state == st_mem_stall1) || (state == st_mem_stall2);

endmodule

`default_nettype wire

//--- cpu_pipeline_slots.sv
// Five-slot instruction pipeline with per-slot PC and the immediate register
`timescale 1ns/1ns
`default_nettype none

`include "cpu_frontend_params.svh"

module cpu_pipeline_slots (
	input  wire                   CLK,
	input  wire                   RSTb,
	input  wire                   take_fetch,
	input  wire                   freeze,
	input  wire                   flush,
	input  wire [`WORD_BITS-1:0]  cache_word,
	input  wire [`PC_BITS-1:0]    fetch_pc,
	output logic [`WORD_BITS-1:0] stage0,
	output logic [`WORD_BITS-1:0] stage1,
	output logic [`WORD_BITS-1:0] stage2,
	output logic [`WORD_BITS-1:0] stage3,
	output logic [`WORD_BITS-1:0] stage4,
	output logic                  stage4_valid,
	output logic [`PC_BITS-1:0]   pc_stage4,
	output logic [`WORD_BITS-1:0] imm_reg,
	pipe_view_if.source           view
);
	import cpu_frontend_pkg::*;

	logic [`WORD_BITS-1:0] word_q [0:4];
	logic [`PC_BITS-1:0]   pc_q [0:4];
	logic [4:0]            valid_q;
	logic                  imm_move;

	// Words and PCs carry no reset, valid bits qualify them
	always_ff @(posedge CLK) begin
		if (take_fetch) begin
			word_q[0] <= cache_word;
			pc_q[0]   <= fetch_pc;
		end
		if (!freeze) begin
			for (int i = 1; i < 5; i++) begin
				word_q[i] <= word_q[i-1];
				pc_q[i]   <= pc_q[i-1];
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			valid_q <= '0;
		end else begin
			// Bubble enters whenever no word is taken
			valid_q[0] <= take_fetch;
			if (!freeze) begin
				// stage0 only moves on with a fetch, else it is refetched later
				valid_q[1] <= valid_q[0] && take_fetch && !flush;
				valid_q[2] <= valid_q[1] && !flush;
				valid_q[3] <= valid_q[2];
				valid_q[4] <= valid_q[3];
			end
		end
	end

	// Valid IMM crossing from stage1 into stage2
	assign imm_move = !freeze && !flush && valid_q[1] &&
		(opcode_t'(word_q[1][15:12]) == op_imm);

	always_ff @(posedge CLK) begin
		if (!RSTb)
			imm_reg <= '0;
		else if (imm_move)
			imm_reg <= {word_q[1][11:0], 4'b0000};
	end

	assign stage0       = word_q[0];
	assign stage1       = word_q[1];
	assign stage2       = word_q[2];
	assign stage3       = word_q[3];
	assign stage4       = word_q[4];
	assign stage4_valid = valid_q[4];
	assign pc_stage4    = pc_q[4];

	// Hazard view of the first four slots
	assign view.s0_word  = word_q[0];
	assign view.s1_word  = word_q[1];
	assign view.s2_word  = word_q[2];
	assign view.s3_word  = word_q[3];
	assign view.s0_valid = valid_q[0];
	assign view.s1_valid = valid_q[1];
	assign view.s2_valid = valid_q[2];
	assign view.s3_valid = valid_q[3];

endmodule

`default_nettype wire

//--- cpu_hazard_check.sv
// Register and flag hazard detection between stage0 and stages 1 to 3
`timescale 1ns/1ns
`default_nettype none

`include "cpu_frontend_params.svh"

module cpu_hazard_check (
	pipe_view_if.sink view,
	output logic      hazard_1,
	output logic      hazard_2,
	output logic      hazard_3
);
	import cpu_frontend_pkg::*;

	// Destination register written
	function automatic logic writes_reg(input logic [`WORD_BITS-1:0] w);
		return opcode_t'(w[15:12]) inside {op_add, op_sub, op_and, op_or, op_ld};
	endfunction

	function automatic logic writes_flags(input logic [`WORD_BITS-1:0] w);
		return opcode_t'(w[15:12]) inside {op_add, op_sub, op_and, op_or, op_cmp};
	endfunction

	// Loads read source a only
	function automatic logic reads_a(input logic [`WORD_BITS-1:0] w);
		return opcode_t'(w[15:12]) inside {op_add, op_sub, op_and, op_or, op_cmp, op_st, op_ld};
	endfunction

	function automatic logic reads_b(input logic [`WORD_BITS-1:0] w);
		return opcode_t'(w[15:12]) inside {op_add, op_sub, op_and, op_or, op_cmp, op_st};
	endfunction

	// Conditional branch depends on flags
	function automatic logic reads_flags(input logic [`WORD_BITS-1:0] w);
		return opcode_t'(w[15:12]) == op_br;
	endfunction

	// Consumer rd against producer wr
	function automatic logic conflict(input logic [`WORD_BITS-1:0] rd,
		input logic [`WORD_BITS-1:0] wr);
		logic [`REG_BITS-1:0] dest;
		logic                 reg_hit;
		logic                 flag_hit;
		dest     = wr[11:8];
		reg_hit  = writes_reg(wr) &&
			((reads_a(rd) && rd[7:4] == dest) || (reads_b(rd) && rd[3:0] == dest));
		flag_hit = reads_flags(rd) && writes_flags(wr);
		return reg_hit || flag_hit;
	endfunction

	// Bubbles never conflict
	assign hazard_1 = view.s0_valid && view.s1_valid && conflict(view.s0_word, view.s1_word);
	assign hazard_2 = view.s0_valid && view.s2_valid && conflict(view.s0_word, view.s2_word);
	assign hazard_3 = view.s0_valid && view.s3_valid && conflict(view.s0_word, view.s3_word);

endmodule

`default_nettype wire

//--- cpu_frontend.sv
// CPU front end top level, fetch control, pipeline slots and hazard check
`timescale 1ns/1ns
`default_nettype none

`include "cpu_frontend_params.svh"

module cpu_frontend (
	input  wire                   CLK,
	input  wire                   RSTb,
	// Instruction cache
	output logic [`PC_BITS-1:0]   cache_request_address,
	input  wire [`WORD_BITS-1:0]  cache_word,
	input  wire                   cache_miss,
	input  wire                   invalidate_cache,
	input  wire                   invalidation_done,
	// Data memory status
	input  wire                   data_memory_was_requested,
	input  wire                   data_memory_success,
	input  wire                   bank_switch,
	// Branch from execute
	input  wire                   load_pc,
	input  wire [`PC_BITS-1:0]    new_pc,
	// Pipeline state
	output logic [`WORD_BITS-1:0] pipeline_stage0,
	output logic [`WORD_BITS-1:0] pipeline_stage1,
	output logic [`WORD_BITS-1:0] pipeline_stage2,
	output logic [`WORD_BITS-1:0] pipeline_stage3,
	output logic [`WORD_BITS-1:0] pipeline_stage4,
	output logic                  stage4_valid,
	output logic [`PC_BITS-1:0]   pc_stage4,
	output logic [`WORD_BITS-1:0] imm_reg
);

	logic take_fetch;
	logic freeze;
	logic flush;
	logic hazard_1;
	logic hazard_2;
	logic hazard_3;

	// Slots to hazard check
	pipe_view_if view ();

	cpu_fetch_control cpu_fetch_control_i (
		.CLK                       (CLK),
		.RSTb                      (RSTb),
		.hazard_1                  (hazard_1),
		.hazard_2                  (hazard_2),
		.hazard_3                  (hazard_3),
		.cache_miss                (cache_miss),
		.invalidate_cache          (invalidate_cache),
		.invalidation_done         (invalidation_done),
		.data_memory_was_requested (data_memory_was_requested),
		.data_memory_success       (data_memory_success),
		.bank_switch               (bank_switch),
		.load_pc                   (load_pc),
		.new_pc                    (new_pc),
		.cache_request_address     (cache_request_address),
		.take_fetch                (take_fetch),
		.freeze                    (freeze),
		.flush                     (flush)
	);

	// Fetched word is tagged with the address it came from
	cpu_pipeline_slots cpu_pipeline_slots_i (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.take_fetch   (take_fetch),
		.freeze       (freeze),
		.flush        (flush),
		.cache_word   (cache_word),
		.fetch_pc     (cache_request_address),
		.stage0       (pipeline_stage0),
		.stage1       (pipeline_stage1),
		.stage2       (pipeline_stage2),
		.stage3       (pipeline_stage3),
		.stage4       (pipeline_stage4),
		.stage4_valid (stage4_valid),
		.pc_stage4    (pc_stage4),
		.imm_reg      (imm_reg),
		.view         (view.source)
	);

	cpu_hazard_check cpu_hazard_check_i (
		.view     (view.sink),
		.hazard_1 (hazard_1),
		.hazard_2 (hazard_2),
		.hazard_3 (hazard_3)
	);

endmodule

`default_nettype wire

//--- cpu_frontend_tb.sv
// Directed testbench for the CPU front end with a cache model and a retirement scoreboard
`timescale 1ns/1ns
`default_nettype none

`include "cpu_frontend_params.svh"

module cpu_frontend_tb;
	import cpu_frontend_pkg::*;

	// Rough cycles per test
	localparam int RESET_LEN      = 40;
	localparam int HAZARD_LEN     = 40;
	localparam int MISS_LEN       = 40;
	localparam int INVALIDATE_LEN = 40;
	localparam int MEM_STALL_LEN  = 40;
	localparam int BRANCH_LEN     = 40;
	localparam int TIMEOUT_CYCLES = 4 * (RESET_LEN + HAZARD_LEN + MISS_LEN +
		INVALIDATE_LEN + MEM_STALL_LEN + BRANCH_LEN);
	localparam int MIN_RETIRED    = 50;
	localparam logic [11:0] IMM_PAYLOAD = 12'hA5C;
	localparam logic [`PC_BITS-1:0] BRANCH_TARGET = 15'd40;

	logic                  CLK;
	logic                  RSTb;
	logic [`PC_BITS-1:0]   cache_request_address;
	logic [`WORD_BITS-1:0] cache_word;
	logic                  cache_miss;
	logic                  invalidate_cache;
	logic                  invalidation_done;
	logic                  data_memory_was_requested;
	logic                  data_memory_success;
	logic                  bank_switch;
	logic                  load_pc;
	logic [`PC_BITS-1:0]   new_pc;
	logic [`WORD_BITS-1:0] pipeline_stage0;
	logic [`WORD_BITS-1:0] pipeline_stage1;
	logic [`WORD_BITS-1:0] pipeline_stage2;
	logic [`WORD_BITS-1:0] pipeline_stage3;
	logic [`WORD_BITS-1:0] pipeline_stage4;
	logic                  stage4_valid;
	logic [`PC_BITS-1:0]   pc_stage4;
	logic [`WORD_BITS-1:0] imm_reg;

	// Cache contents, 64 words repeating over the address space
	logic [`WORD_BITS-1:0] program_mem [0:63];

	// Test side controls for the scoreboard
	string                 test_name;
	logic                  hold_active;
	logic                  jump_req;
	logic [`PC_BITS-1:0]   flush_pc;

	// Scoreboard state
	logic [`PC_BITS-1:0]   expected_pc;
	int                    retired_count;
	logic                  jump_seen;
	logic                  last_valid;
	logic [`PC_BITS-1:0]   last_pc;
	int                    cycle_count = 0;

	cpu_frontend cpu_frontend_i (
		.CLK                       (CLK),
		.RSTb                      (RSTb),
		.cache_request_address     (cache_request_address),
		.cache_word                (cache_word),
		.cache_miss                (cache_miss),
		.invalidate_cache          (invalidate_cache),
		.invalidation_done         (invalidation_done),
		.data_memory_was_requested (data_memory_was_requested),
		.data_memory_success       (data_memory_success),
		.bank_switch               (bank_switch),
		.load_pc                   (load_pc),
		.new_pc                    (new_pc),
		.pipeline_stage0           (pipeline_stage0),
		.pipeline_stage1           (pipeline_stage1),
		.pipeline_stage2           (pipeline_stage2),
		.pipeline_stage3           (pipeline_stage3),
		.pipeline_stage4           (pipeline_stage4),
		.stage4_valid              (stage4_valid),
		.pc_stage4                 (pc_stage4),
		.imm_reg                   (imm_reg)
	);

	// Combinational cache read
	assign cache_word = program_mem[cache_request_address[5:0]];

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
			$display("Test failures found");
			$fatal(1, "Stopping at first error");
		end
	endtask

	// Random words write nothing, hazards and the IMM are planted
	task automatic build_program();
		opcode_t op;
		for (int i = 0; i < 64; i++) begin
			op = ($urandom_range(1) == 0) ? op_nop : op_st;
			program_mem[i] = {op, 4'($urandom_range(15)), 4'($urandom_range(15)),
				4'($urandom_range(15))};
		end
		// r5 written then read straight after
		program_mem[8]  = {op_add, 4'd5, 4'd1, 4'd2};
		program_mem[9]  = {op_st, 4'd0, 4'd5, 4'd3};
		// Flags set then used
		program_mem[12] = {op_cmp, 4'd0, 4'd1, 4'd2};
		program_mem[13] = {op_br, 12'h004};
		program_mem[16] = {op_imm, IMM_PAYLOAD};
	endtask

	task automatic wait_for_address(input logic [`PC_BITS-1:0] target);
		while (expected_pc < target)
			@(posedge CLK);
	endtask

	task automatic wait_retirements(input int count);
		int target;
		@(posedge CLK);
		target = retired_count + count;
		while (retired_count < target)
			@(posedge CLK);
	endtask

	task automatic check_stage4_held(input logic [`PC_BITS-1:0] pc,
		input logic [`WORD_BITS-1:0] word);
		@(negedge CLK);
		check_value(test_name, 32'd1, 32'(stage4_valid));
		check_value(test_name, 32'(pc), 32'(pc_stage4));
		check_value(test_name, 32'(word), 32'(pipeline_stage4));
	endtask

	// Clean stream with address 3 in stage4, so stages 3 to 0 hold 4 to 7
	task automatic check_stream_slots();
		@(negedge CLK);
		check_value(test_name, 32'd1, 32'(stage4_valid));
		check_value(test_name, 32'd3, 32'(pc_stage4));
		check_value(test_name, 32'(program_mem[4]), 32'(pipeline_stage3));
		check_value(test_name, 32'(program_mem[5]), 32'(pipeline_stage2));
		check_value(test_name, 32'(program_mem[6]), 32'(pipeline_stage1));
		check_value(test_name, 32'(program_mem[7]), 32'(pipeline_stage0));
		// Next fetch already addressed
		check_value(test_name, 32'd8, 32'(cache_request_address));
	endtask

	task automatic reset_invalidation_test();
		test_name = "reset and invalidation";
		// FSM sits waiting for the cache flush
		repeat (8) begin
			@(negedge CLK);
			check_value(test_name, 32'd0, 32'(stage4_valid));
		end
		@(posedge CLK);
		invalidation_done <= 1'b1;
		@(posedge CLK);
		invalidation_done <= 1'b0;
		wait_for_address(15'd3);
		check_stream_slots();
		wait_for_address(15'd6);
	endtask

	// Register hazard at 8/9, flag hazard at 12/13
	task automatic hazard_test();
		test_name = "hazards";
		wait_for_address(15'd20);
	endtask

	task automatic immediate_test();
		test_name = "immediate";
		check_value(test_name, 32'({IMM_PAYLOAD, 4'b0000}), 32'(imm_reg));
	endtask

	task automatic cache_miss_test();
		test_name = "cache miss";
		@(posedge CLK);
		cache_miss <= 1'b1;
		// Older words drain from stages 1 to 4 first
		repeat (4) @(negedge CLK);
		repeat (6) begin
			@(negedge CLK);
			check_value(test_name, 32'd0, 32'(stage4_valid));
		end
		@(posedge CLK);
		cache_miss <= 1'b0;
		wait_retirements(10);
	endtask

	task automatic invalidate_test();
		test_name = "invalidate cache";
		@(posedge CLK);
		invalidate_cache <= 1'b1;
		@(posedge CLK);
		invalidate_cache <= 1'b0;
		repeat (3) @(negedge CLK);
		// Drained, and still waiting for invalidation_done
		repeat (6) begin
			@(negedge CLK);
			check_value(test_name, 32'd0, 32'(stage4_valid));
		end
		@(posedge CLK);
		invalidation_done <= 1'b1;
		@(posedge CLK);
		invalidation_done <= 1'b0;
		wait_retirements(10);
	endtask

	task automatic memory_stall_test();
		logic [`PC_BITS-1:0]   held_pc;
		logic [`WORD_BITS-1:0] held_word;
		test_name = "memory stall";
		@(posedge CLK);
		hold_active = 1'b1;
		data_memory_was_requested <= 1'b1;
		data_memory_success       <= 1'b0;
		bank_switch               <= 1'b1;
		@(negedge CLK);
		held_pc   = pc_stage4;
		held_word = pipeline_stage4;
		check_value(test_name, 32'd1, 32'(stage4_valid));
		repeat (3) check_stage4_held(held_pc, held_word);
		@(posedge CLK);
		data_memory_was_requested <= 1'b0;
		data_memory_success       <= 1'b1;
		// Bank switch keeps the later stages frozen
		repeat (3) check_stage4_held(held_pc, held_word);
		@(posedge CLK);
		bank_switch <= 1'b0;
		check_stage4_held(held_pc, held_word);
		wait_retirements(10);
		hold_active = 1'b0;
	endtask

	task automatic branch_test();
		test_name = "branch";
		@(posedge CLK);
		load_pc <= 1'b1;
		new_pc  <= BRANCH_TARGET;
		@(negedge CLK);
		// Next fetch address, cancelled by the branch
		flush_pc = cache_request_address;
		jump_req = 1'b1;
		@(posedge CLK);
		load_pc <= 1'b0;
		while (!jump_seen)
			@(posedge CLK);
		wait_for_address(BRANCH_TARGET + 15'd6);
	endtask

	// Retirement check, stage4 is stable at the falling edge
	always @(negedge CLK) begin
		if (!RSTb) begin
			expected_pc   = '0;
			retired_count = 0;
			jump_seen     = 1'b0;
			last_valid    = 1'b0;
			last_pc       = '0;
		end else begin
			if (stage4_valid === 1'b1) begin
				if (hold_active && last_valid && pc_stage4 == last_pc) begin
					// Same entry, frozen by the memory stall
				end else begin
					if (jump_req && !jump_seen && pc_stage4 != expected_pc) begin
						// Stage0 and stage1 words at the branch never retire
						check_value(test_name, 32'd1, 32'(expected_pc + 15'd2 <= flush_pc));
						expected_pc = BRANCH_TARGET;
						jump_seen   = 1'b1;
					end
					check_value(test_name, 32'(expected_pc), 32'(pc_stage4));
					check_value(test_name, 32'(program_mem[expected_pc[5:0]]),
						32'(pipeline_stage4));
					expected_pc   = expected_pc + 1'b1;
					retired_count = retired_count + 1;
				end
			end
			last_valid = (stage4_valid === 1'b1);
			last_pc    = pc_stage4;
		end
	end

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the pipeline stopped retiring", cycle_count);
			$display("Test failures found");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		void'($urandom(14));
		build_program();
		RSTb                      = 1'b0;
		cache_miss                = 1'b0;
		invalidate_cache          = 1'b0;
		invalidation_done         = 1'b0;
		data_memory_was_requested = 1'b0;
		data_memory_success       = 1'b1;
		bank_switch               = 1'b0;
		load_pc                   = 1'b0;
		new_pc                    = '0;
		hold_active               = 1'b0;
		jump_req                  = 1'b0;
		flush_pc                  = '0;
		test_name                 = "reset";
		repeat (10) @(posedge CLK);
		RSTb <= 1'b1;
		reset_invalidation_test();
		hazard_test();
		immediate_test();
		cache_miss_test();
		invalidate_test();
		memory_stall_test();
		branch_test();
		@(posedge CLK);
		if (retired_count >= MIN_RETIRED) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Only %0d words retired, fewer than the tests need", retired_count);
			$display("Test failures found");
			$fatal(1, "Run incomplete");
		end
	end

endmodule

`default_nettype wire

//--- cpu_frontend.f
+incdir+.
cpu_frontend_pkg.sv
pipe_view_if.sv
cpu_fetch_control.sv
cpu_pipeline_slots.sv
cpu_hazard_check.sv
cpu_frontend.sv
cpu_frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the CPU front end testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f cpu_frontend.f --top-module cpu_frontend_tb -o cpu_frontend_sim
./obj_dir/cpu_frontend_sim 2>&1 | tee sim.log
if grep -q "Test failures found" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
	echo "Simulation ended without a pass line"
	exit 1
fi
echo "Simulation PASSED"
